/* lsu_load_align.sv */
`timescale 1ns/1ps

module lsu_load_align (
	input  logic               clock,
	input  logic               reset,
	input  logic               rd_done,
	input  lsu_pkg::bus_data_t rd_data,
	input  logic               second_beat,
	input  lsu_pkg::mem_op_t   op,
	input  lsu_pkg::addr_t     addr,
	output logic [31:0]        resp_data
);

	localparam int WB = lsu_pkg::WORD_BYTES;

	lsu_pkg::bus_data_t                   first_q;
	lsu_pkg::lane_strb_t                  first_lanes;
	logic [WB-1:0]                        word_lanes;
	logic [$clog2(lsu_pkg::BUS_BYTES)-1:0] lane;
	logic [8*WB-1:0]                      word;

	// hold the first beat of a split load
	always_ff @(posedge clock) begin
		if (reset)
			first_q <= '0;
		else if (rd_done && !second_beat)
			first_q <= rd_data;
	end

	// lanes from the start address up to the split boundary
	assign word_lanes = {WB{1'b1}} << addr[1:0];
	assign first_lanes = addr[2] ? {word_lanes, {WB{1'b0}}} : {{WB{1'b0}}, word_lanes};

	// ------------------------------------------------------------------------
	// byte gather
	// ------------------------------------------------------------------------
	always_comb begin
		lane = '0;
		word = '0;
		for (int i = 0; i < WB; i++) begin
			lane = addr[2:0] + i[2:0];
			if (second_beat && first_lanes[lane])
				word[8*i +: 8] = first_q[8*lane +: 8];
			else
				word[8*i +: 8] = rd_data[8*lane +: 8];
		end
	end

	// extension by access kind
	always_comb begin
		case (op)
			lsu_pkg::LB: resp_data = {{24{word[7]}}, word[7:0]};
			lsu_pkg::LBU: resp_data = {24'b0, word[7:0]};
			lsu_pkg::LH: resp_data = {{16{word[15]}}, word[15:0]};
			lsu_pkg::LHU: resp_data = {16'b0, word[15:0]};
			default: resp_data = word;
		endcase
	end

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

	// ------------------------------------------------------------------------
	// access kinds seen by the load/store unit
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		LB  = 3'd0,
		LH  = 3'd1,
		LW  = 3'd2,
		LBU = 3'd3,
		LHU = 3'd4,
		SB  = 3'd5,
		SH  = 3'd6,
		SW  = 3'd7
	} mem_op_t;

	// ------------------------------------------------------------------------
	// bus geometry
	// ------------------------------------------------------------------------
	// byte lanes on the data bus
	localparam int BUS_BYTES = 8;
	// word size, also the beat-split boundary
	localparam int WORD_BYTES = 4;

	typedef logic [BUS_BYTES-1:0]   lane_strb_t;
	typedef logic [8*BUS_BYTES-1:0] bus_data_t;
	typedef logic [31:0]            addr_t;

endpackage

/* lsu_read_engine.sv */
`timescale 1ns/1ps

module lsu_read_engine (
	input  logic               clock,
	input  logic               reset,
	input  logic               rd_start,
	input  lsu_pkg::addr_t     beat_addr,
	output logic               rd_done,
	output lsu_pkg::bus_data_t rd_data,
	output logic               ar_valid,
	input  logic               ar_ready,
	output lsu_pkg::addr_t     ar_addr,
	input  logic               r_valid,
	output logic               r_ready,
	input  lsu_pkg::bus_data_t r_data
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ADDR = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;

	logic [1:0]         state;
	lsu_pkg::bus_data_t data_q;

	// one read beat, ar then r
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			ar_valid <= 1'b0;
			r_ready <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (rd_start) begin
					state <= ST_ADDR;
					ar_valid <= 1'b1;
				end
				ST_ADDR: if (ar_ready) begin
					state <= ST_DATA;
					ar_valid <= 1'b0;
					r_ready <= 1'b1;
				end
				ST_DATA: if (r_valid) begin
					state <= ST_IDLE;
					r_ready <= 1'b0;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request stage holds the beat address for the whole beat
	assign ar_addr = beat_addr;
	assign rd_done = r_valid && r_ready;

	always_ff @(posedge clock) begin
		if (rd_done)
			data_q <= r_data;
	end

	// live bus word in the done cycle, held copy afterwards
	assign rd_data = rd_done ? r_data : data_q;

endmodule

/* lsu_request.sv */
`timescale 1ns/1ps

module lsu_request (
	input  logic                clock,
	input  logic                reset,
	input  logic                req_valid,
	input  lsu_pkg::mem_op_t    req_op,
	input  lsu_pkg::addr_t      req_addr,
	input  logic [31:0]         req_wdata,
	output logic                req_ready,
	output logic                rd_start,
	output logic                wr_start,
	input  logic                rd_done,
	input  logic                wr_done,
	output lsu_pkg::addr_t      beat_addr,
	output lsu_pkg::lane_strb_t beat_strb,
	output lsu_pkg::bus_data_t  beat_wdata,
	output lsu_pkg::mem_op_t    op,
	output lsu_pkg::addr_t      addr,
	output logic                second_beat,
	output logic                resp_valid
);

	localparam int BUS_W = 8 * lsu_pkg::BUS_BYTES;
	localparam int WB = lsu_pkg::WORD_BYTES;

	logic                       busy;
	logic                       start_q;
	logic                       accept;
	logic                       done;
	logic                       is_store;
	logic                       two_beat;
	logic [31:0]                wdata_q;
	logic [WB-1:0]              size_mask;
	lsu_pkg::lane_strb_t        span;
	lsu_pkg::lane_strb_t        first_strb;
	lsu_pkg::lane_strb_t        second_strb;
	lsu_pkg::addr_t             second_addr;
	logic [2*BUS_W-1:0]         wdata_dbl;

	assign accept = req_valid && req_ready;
	assign done = rd_done || wr_done;
	// a new request may overlap the response cycle of the old one
	assign req_ready = !busy || resp_valid;

	// ------------------------------------------------------------------------
	// request register and beat sequencing
	// ------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (accept) begin
			op <= req_op;
			addr <= req_addr;
			wdata_q <= req_wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			start_q <= 1'b0;
			second_beat <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			start_q <= accept || (done && two_beat && !second_beat);
			resp_valid <= done && (!two_beat || second_beat);
			if (accept)
				busy <= 1'b1;
			else if (resp_valid)
				busy <= 1'b0;
			if (accept)
				second_beat <= 1'b0;
			else if (done && two_beat)
				second_beat <= 1'b1;
		end
	end

	assign is_store = op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
	assign rd_start = start_q && !is_store;
	assign wr_start = start_q && is_store;

	// ------------------------------------------------------------------------
	// beat address, strobes and write data
	// ------------------------------------------------------------------------
	always_comb begin
		case (op)
			lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: size_mask = 4'b0001;
			lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	// bytes of the access relative to its word, upper half spills past the boundary
	assign span = {{WB{1'b0}}, size_mask} << addr[1:0];
	assign two_beat = |span[2*WB-1:WB];

	// lane half chosen by address bit 2
	assign first_strb = addr[2] ? {span[WB-1:0], {WB{1'b0}}} : {{WB{1'b0}}, span[WB-1:0]};
	assign second_strb = addr[2] ? {{WB{1'b0}}, span[2*WB-1:WB]} : {span[2*WB-1:WB], {WB{1'b0}}};
	assign second_addr = {addr[31:2], 2'b00} + lsu_pkg::addr_t'(WB);

	assign beat_addr = second_beat ? second_addr : addr;
	assign beat_strb = second_beat ? second_strb : first_strb;

	// rotate store value left by the byte offset within the bus word
	assign wdata_dbl = {2{lsu_pkg::bus_data_t'(wdata_q)}} << {addr[2:0], 3'b000};
	assign beat_wdata = wdata_dbl[2*BUS_W-1 -: BUS_W];

endmodule

/* lsu_top.f */
lsu_pkg.sv
lsu_request.sv
lsu_read_engine.sv
lsu_write_engine.sv
lsu_load_align.sv
lsu_top.sv
tb_clock_gen.sv
lsu_top_assert.sv
lsu_top_tb.sv

/* lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
	input  logic               clock,
	input  logic               reset,
	// pipeline side
	input  logic               req_valid,
	input  lsu_pkg::mem_op_t   req_op,
	input  lsu_pkg::addr_t     req_addr,
	input  logic [31:0]        req_wdata,
	output logic               req_ready,
	output logic               resp_valid,
	output logic [31:0]        resp_data,
	// read channels
	output logic               ar_valid,
	input  logic               ar_ready,
	output lsu_pkg::addr_t     ar_addr,
	input  logic               r_valid,
	output logic               r_ready,
	input  lsu_pkg::bus_data_t r_data,
	// write channels
	output logic               aw_valid,
	input  logic               aw_ready,
	output lsu_pkg::addr_t     aw_addr,
	output logic               w_valid,
	input  logic               w_ready,
	output lsu_pkg::bus_data_t w_data,
	output logic [7:0]         w_strb,
	input  logic               b_valid,
	output logic               b_ready
);

	logic                rd_start;
	logic                wr_start;
	logic                rd_done;
	logic                wr_done;
	lsu_pkg::addr_t      beat_addr;
	lsu_pkg::lane_strb_t beat_strb;
	lsu_pkg::bus_data_t  beat_wdata;
	lsu_pkg::bus_data_t  rd_data;
	lsu_pkg::mem_op_t    op;
	lsu_pkg::addr_t      addr;
	logic                second_beat;

	lsu_request u_request (
		.clock(clock), .reset(reset),
		.req_valid(req_valid), .req_op(req_op), .req_addr(req_addr),
		.req_wdata(req_wdata), .req_ready(req_ready),
		.rd_start(rd_start), .wr_start(wr_start),
		.rd_done(rd_done), .wr_done(wr_done),
		.beat_addr(beat_addr), .beat_strb(beat_strb), .beat_wdata(beat_wdata),
		.op(op), .addr(addr), .second_beat(second_beat),
		.resp_valid(resp_valid)
	);

	lsu_read_engine u_read_engine (
		.clock(clock), .reset(reset),
		.rd_start(rd_start), .beat_addr(beat_addr),
		.rd_done(rd_done), .rd_data(rd_data),
		.ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
		.r_valid(r_valid), .r_ready(r_ready), .r_data(r_data)
	);

	lsu_write_engine u_write_engine (
		.clock(clock), .reset(reset),
		.wr_start(wr_start), .beat_addr(beat_addr),
		.beat_strb(beat_strb), .beat_wdata(beat_wdata), .wr_done(wr_done),
		.aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
		.w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_strb(w_strb),
		.b_valid(b_valid), .b_ready(b_ready)
	);

	lsu_load_align u_load_align (
		.clock(clock), .reset(reset),
		.rd_done(rd_done), .rd_data(rd_data),
		.second_beat(second_beat), .op(op), .addr(addr),
		.resp_data(resp_data)
	);

endmodule

/* lsu_top_assert.sv */
`timescale 1ns/1ps

module lsu_top_assert (
	input logic                clock,
	input logic                reset,
	input logic                ar_valid,
	input logic                ar_ready,
	input lsu_pkg::addr_t      ar_addr,
	input logic                aw_valid,
	input logic                aw_ready,
	input lsu_pkg::addr_t      aw_addr,
	input logic                w_valid,
	input logic                w_ready,
	input lsu_pkg::bus_data_t  w_data,
	input lsu_pkg::lane_strb_t w_strb
);

	int   fail_count = 0;
	logic aw_seen;

	// aw transfer done, its w transfer still open
	always_ff @(posedge clock) begin
		if (reset)
			aw_seen <= 1'b0;
		else if (aw_valid && aw_ready)
			aw_seen <= 1'b1;
		else if (w_valid && w_ready)
			aw_seen <= 1'b0;
	end

	// ------------------------------------------------------------------------
	// valids hold with a stable payload until the transfer
	// ------------------------------------------------------------------------
	ar_held: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
	else begin
		fail_count++;
		$error("ar_valid or ar_addr changed before the ar transfer");
	end

	aw_held: assert property (@(posedge clock) disable iff (reset)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
	else begin
		fail_count++;
		$error("aw_valid or aw_addr changed before the aw transfer");
	end

	w_held: assert property (@(posedge clock) disable iff (reset)
		w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
	else begin
		fail_count++;
		$error("w_valid, w_data or w_strb changed before the w transfer");
	end

	w_strb_set: assert property (@(posedge clock) disable iff (reset)
		w_valid |-> w_strb != '0)
	else begin
		fail_count++;
		$error("w_valid high with an empty w_strb");
	end

	// write data only after its address
	w_after_aw: assert property (@(posedge clock) disable iff (reset)
		$rose(w_valid) |-> aw_seen)
	else begin
		fail_count++;
		$error("w_valid rose before the aw transfer");
	end

endmodule

/* lsu_top_tb.sv */
`timescale 1ns/1ps

module lsu_top_tb;

	localparam int CYCLES_PER_ENTRY = 40;

	logic               clock;
	logic               reset;
	logic               req_valid;
	lsu_pkg::mem_op_t   req_op;
	lsu_pkg::addr_t     req_addr;
	logic [31:0]        req_wdata;
	logic               req_ready;
	logic               resp_valid;
	logic [31:0]        resp_data;
	logic               ar_valid, ar_ready, r_valid, r_ready;
	logic               aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
	lsu_pkg::addr_t     ar_addr;
	lsu_pkg::addr_t     aw_addr;
	lsu_pkg::bus_data_t r_data;
	lsu_pkg::bus_data_t w_data;
	logic [7:0]         w_strb;

	// stimulus table, one entry per access
	lsu_pkg::mem_op_t    tbl_op[$];
	lsu_pkg::addr_t      tbl_addr[$];
	logic [31:0]         tbl_wdata[$];
	logic [31:0]         tbl_expect[$];

	// memory model and the transfers it saw
	logic [7:0]          mem [256];
	logic [7:0]          ref_mem [256];
	logic [31:0]         lfsr = 32'hd8c68621;
	int                  ar_wait, r_wait, aw_wait, w_wait, b_wait;
	logic                rd_pend;
	logic                b_pend;
	lsu_pkg::addr_t      rd_addr;
	lsu_pkg::addr_t      wr_addr;
	lsu_pkg::addr_t      rd_beats[$];
	lsu_pkg::addr_t      wr_beats[$];
	lsu_pkg::lane_strb_t wr_strbs[$];
	lsu_pkg::bus_data_t  wr_datas[$];
	int                  pending[$];
	int                  drive_idx;
	int                  resp_count;

	tb_clock_gen u_clock_gen (.clock(clock));

	lsu_top u_dut (.*);

	bind lsu_top lsu_top_assert u_assert (.*);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			fail_run($sformatf("Mismatch at %0t: %s got 0x%0h, expected 0x%0h",
				$time, name, got, exp));
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// two bits per draw, a stall of 0 to 3 cycles
	task automatic draw_delay(output int d);
		d = 0;
		repeat (2) begin
			d = (d << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic stall_over(inout int cnt);
		if (cnt == 0)
			return 1'b1;
		cnt--;
		return 1'b0;
	endfunction

	function automatic lsu_pkg::bus_data_t bus_word(input lsu_pkg::addr_t a);
		lsu_pkg::bus_data_t w;
		for (int k = 0; k < 8; k++)
			w[8*k +: 8] = mem[{a[7:3], 3'(k)}];
		return w;
	endfunction

	task automatic add_entry(input lsu_pkg::mem_op_t op, input lsu_pkg::addr_t a,
			input logic [31:0] wdata, input logic [31:0] exp_val);
		tbl_op.push_back(op);
		tbl_addr.push_back(a);
		tbl_wdata.push_back(wdata);
		tbl_expect.push_back(exp_val);
	endtask

	// memory starts as addr ^ 8'ha5, loads of untouched bytes expect that
	task automatic load_table();
		add_entry(lsu_pkg::SB,  32'h10, 32'h11223385, 32'h0);
		add_entry(lsu_pkg::LB,  32'h10, 32'h0, 32'hffffff85);
		add_entry(lsu_pkg::LBU, 32'h10, 32'h0, 32'h00000085);
		add_entry(lsu_pkg::SH,  32'h22, 32'h55669abc, 32'h0);
		add_entry(lsu_pkg::LH,  32'h22, 32'h0, 32'hffff9abc);
		add_entry(lsu_pkg::LHU, 32'h22, 32'h0, 32'h00009abc);
		add_entry(lsu_pkg::SW,  32'h34, 32'hdeadbeef, 32'h0);
		add_entry(lsu_pkg::LW,  32'h34, 32'h0, 32'hdeadbeef);
		add_entry(lsu_pkg::SW,  32'h43, 32'h12345678, 32'h0);
		add_entry(lsu_pkg::LW,  32'h43, 32'h0, 32'h12345678);
		add_entry(lsu_pkg::SH,  32'h57, 32'h7788c3d2, 32'h0);
		add_entry(lsu_pkg::LH,  32'h57, 32'h0, 32'hffffc3d2);
		add_entry(lsu_pkg::LHU, 32'h57, 32'h0, 32'h0000c3d2);
		add_entry(lsu_pkg::SW,  32'h66, 32'ha1b2c3d4, 32'h0);
		add_entry(lsu_pkg::LW,  32'h66, 32'h0, 32'ha1b2c3d4);
		add_entry(lsu_pkg::LH,  32'h65, 32'h0, 32'hffffd4c0);
		add_entry(lsu_pkg::LB,  32'h69, 32'h0, 32'hffffffa1);
		add_entry(lsu_pkg::LBU, 32'h68, 32'h0, 32'h000000b2);
		add_entry(lsu_pkg::LW,  32'h13, 32'h0, 32'hb3b0b1b6);
		add_entry(lsu_pkg::LHU, 32'h0f, 32'h0, 32'h000085aa);
	endtask

	// ------------------------------------------------------------------------
	// expected beats and results of one finished access
	// ------------------------------------------------------------------------
	task automatic check_response(input int idx);
		lsu_pkg::mem_op_t    op;
		lsu_pkg::addr_t      a;
		lsu_pkg::addr_t      bound;
		lsu_pkg::addr_t      lo;
		lsu_pkg::addr_t      hi;
		lsu_pkg::lane_strb_t strb;
		lsu_pkg::bus_data_t  exp_data;
		int                  size;
		int                  n_first;
		int                  beats;
		logic                is_store;

		op = tbl_op[idx];
		a = tbl_addr[idx];
		case (op)
			lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: size = 1;
			lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: size = 2;
			default: size = 4;
		endcase
		// first beat ends at the next 4-byte boundary
		bound = {a[31:2], 2'b00} + 32'd4;
		if (bound - a < size)
			n_first = int'(bound - a);
		else
			n_first = size;
		beats = (n_first < size) ? 2 : 1;
		is_store = op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
		// store byte i sits on the lane of address a+i
		exp_data = '0;
		for (int i = 0; i < 4; i++)
			exp_data[8*((a[2:0] + i) % 8) +: 8] = tbl_wdata[idx][8*i +: 8];

		check_value("aw/w transfers", wr_beats.size(), is_store ? beats : 0);
		check_value("ar/r transfers", rd_beats.size(), is_store ? 0 : beats);
		for (int beat = 0; beat < beats; beat++) begin
			lo = (beat == 0) ? a : bound;
			hi = (beat == 0) ? a + n_first : a + size;
			strb = '0;
			for (lsu_pkg::addr_t x = lo; x < hi; x++)
				strb[x[2:0]] = 1'b1;
			if (is_store) begin
				check_value("aw_addr", wr_beats[beat], lo);
				check_value("w_strb", wr_strbs[beat], strb);
				check_value("w_data", wr_datas[beat], exp_data);
			end else begin
				check_value("ar_addr", rd_beats[beat], lo);
			end
		end

		if (is_store) begin
			for (int i = 0; i < size; i++)
				ref_mem[8'(a + i)] = tbl_wdata[idx][8*i +: 8];
			for (int m = 0; m < 256; m++)
				check_value($sformatf("mem[0x%0h]", m), mem[m], ref_mem[m]);
		end else begin
			check_value("resp_data", resp_data, tbl_expect[idx]);
		end
		rd_beats.delete();
		wr_beats.delete();
		wr_strbs.delete();
		wr_datas.delete();
	endtask

	// ------------------------------------------------------------------------
	// bus memory model with random stalls
	// ------------------------------------------------------------------------
	always @(posedge clock) begin
		if (reset) begin
			{ar_ready, r_valid, aw_ready, w_ready, b_valid} <= '0;
			r_data <= '0;
			rd_pend = 1'b0;
			b_pend = 1'b0;
			{ar_wait, r_wait, aw_wait, w_wait, b_wait} = '0;
		end else begin
			if (ar_valid && ar_ready) begin
				ar_ready <= 1'b0;
				rd_addr = ar_addr;
				rd_beats.push_back(ar_addr);
				rd_pend = 1'b1;
				draw_delay(ar_wait);
			end else if (ar_valid && stall_over(ar_wait)) begin
				ar_ready <= 1'b1;
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				rd_pend = 1'b0;
				draw_delay(r_wait);
			end else if (rd_pend && !r_valid && stall_over(r_wait)) begin
				r_valid <= 1'b1;
				r_data <= bus_word(rd_addr);
			end
			if (aw_valid && aw_ready) begin
				aw_ready <= 1'b0;
				wr_addr = aw_addr;
				draw_delay(aw_wait);
			end else if (aw_valid && stall_over(aw_wait)) begin
				aw_ready <= 1'b1;
			end
			// strobed byte writes
			if (w_valid && w_ready) begin
				w_ready <= 1'b0;
				wr_beats.push_back(wr_addr);
				wr_strbs.push_back(w_strb);
				wr_datas.push_back(w_data);
				for (int k = 0; k < 8; k++)
					if (w_strb[k])
						mem[{wr_addr[7:3], 3'(k)}] = w_data[8*k +: 8];
				b_pend = 1'b1;
				draw_delay(w_wait);
			end else if (w_valid && stall_over(w_wait)) begin
				w_ready <= 1'b1;
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				b_pend = 1'b0;
				draw_delay(b_wait);
			end else if (b_pend && !b_valid && stall_over(b_wait)) begin
				b_valid <= 1'b1;
			end
		end
	end

	// one response per accepted request, one access in flight
	always @(posedge clock) begin
		if (!reset) begin
			if (u_dut.u_assert.fail_count != 0)
				fail_run("a bus handshake assertion failed");
			if (resp_valid) begin
				if (pending.size() == 0) begin
					fail_run("resp_valid pulsed with no request outstanding");
				end else begin
					check_response(pending.pop_front());
					resp_count++;
				end
			end
			if (req_valid && req_ready) begin
				if (pending.size() != 0)
					fail_run("a second request was taken while an access was in flight");
				else
					pending.push_back(drive_idx);
			end
		end
	end

	initial begin
		for (int m = 0; m < 256; m++) begin
			mem[m] = 8'(m) ^ 8'ha5;
			ref_mem[m] = 8'(m) ^ 8'ha5;
		end
		load_table();
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = lsu_pkg::LW;
		req_addr = '0;
		req_wdata = '0;
		{ar_ready, r_valid, aw_ready, w_ready, b_valid} = '0;
		r_data = '0;
		drive_idx = 0;
		resp_count = 0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check_value("req_ready", req_ready, 1'b1);
		check_value("ar_valid/r_ready/aw_valid/w_valid/b_ready",
			{ar_valid, r_ready, aw_valid, w_valid, b_ready}, '0);

		// next request waits on req_ready while the previous one runs
		for (int k = 0; k < tbl_op.size(); k++) begin
			req_valid <= 1'b1;
			req_op <= tbl_op[k];
			req_addr <= tbl_addr[k];
			req_wdata <= tbl_wdata[k];
			drive_idx <= k;
			do
				@(posedge clock);
			while (!req_ready);
		end
		req_valid <= 1'b0;
		wait (resp_count == tbl_op.size());
		@(posedge clock);
		if (u_dut.u_assert.fail_count == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			$display("%0d bus handshake assertions failed", u_dut.u_assert.fail_count);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	// watchdog
	initial begin
		@(posedge clock);
		repeat (20 + CYCLES_PER_ENTRY * tbl_op.size()) @(posedge clock);
		fail_run("Timeout: not every request received a response");
	end

endmodule

/* lsu_write_engine.sv */
`timescale 1ns/1ps

module lsu_write_engine (
	input  logic                clock,
	input  logic                reset,
	input  logic                wr_start,
	input  lsu_pkg::addr_t      beat_addr,
	input  lsu_pkg::lane_strb_t beat_strb,
	input  lsu_pkg::bus_data_t  beat_wdata,
	output logic                wr_done,
	output logic                aw_valid,
	input  logic                aw_ready,
	output lsu_pkg::addr_t      aw_addr,
	output logic                w_valid,
	input  logic                w_ready,
	output lsu_pkg::bus_data_t  w_data,
	output lsu_pkg::lane_strb_t w_strb,
	input  logic                b_valid,
	output logic                b_ready
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ADDR = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_RESP = 2'd3;

	logic [1:0] state;

	// ------------------------------------------------------------------------
	// aw, then w, then b, strictly in order
	// ------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_IDLE;
			aw_valid <= 1'b0;
			w_valid <= 1'b0;
			b_ready <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (wr_start) begin
					state <= ST_ADDR;
					aw_valid <= 1'b1;
				end
				ST_ADDR: if (aw_ready) begin
					state <= ST_DATA;
					aw_valid <= 1'b0;
					w_valid <= 1'b1;
				end
				ST_DATA: if (w_ready) begin
					state <= ST_RESP;
					w_valid <= 1'b0;
					b_ready <= 1'b1;
				end
				ST_RESP: if (b_valid) begin
					state <= ST_IDLE;
					b_ready <= 1'b0;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// payload is stable from the request stage until wr_done
	assign aw_addr = beat_addr;
	assign w_data = beat_wdata;
	assign w_strb = beat_strb;

	// beat ends on the b transfer
	assign wr_done = b_valid && b_ready;

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock
);

	// 4 ns period
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

endmodule
